// File: bench/schedTb.sv
`timescale 1ns/100ps

module schedTb;

	localparam int QUEUE_DEPTH = 6;
	localparam int READ_PERIOD = 8;
	localparam int NUM_Q = 4;
	// fill level up to which the latency-weighted score applies
	localparam int DIRECT_LIMIT = 3;

	// button timing in clock cycles
	localparam int HOLD_CYCLES = 3;
	localparam int LONG_HOLD = 10;
	localparam int RELEASE_CYCLES = 3;
	localparam int RANDOM_ENTRIES = 12;
	localparam int RANDOM_READS = 13;
	localparam int FILL_ENTRIES = 7;

	// watchdog budget from the test lengths, doubled for margin
	localparam int ENTRY_CYCLES = 4 + 4 * (LONG_HOLD + RELEASE_CYCLES);
	localparam int NUM_ENTRIES = 1 + RANDOM_ENTRIES + FILL_ENTRIES;
	localparam int NUM_READS = RANDOM_READS + 1 + FILL_ENTRIES;
	localparam int WATCHDOG_NS =
		2 * (NUM_ENTRIES * ENTRY_CYCLES + NUM_READS * (READ_PERIOD + 2) + 50) * 10;

	logic CLOCK_50;
	logic rst;
	logic btnStart;
	logic btn0;
	logic btn1;
	logic readEn;
	schedPkg::packet_t lastEntry;
	schedPkg::packet_t readOut;
	schedPkg::bcd_t readCount;

	// queue models, oldest entry at index 0
	schedPkg::payload_t modelMem [NUM_Q][QUEUE_DEPTH];
	int modelCount [NUM_Q];

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int readsSeen = 0;
	int q0Reads = 0;
	int readEdges = 0;
	integer seed = 32'hf488;
	schedPkg::packet_t expRead;

	tbClock #(
		.PERIOD_NS(10),
		.RESET_CYCLES(5)
	) clockGen (
		.CLOCK_50(CLOCK_50),
		.rst_o(rst)
	);

	packetScheduler #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.READ_PERIOD(READ_PERIOD)
	) DUT (
		.CLOCK_50(CLOCK_50),
		.rst_i(rst),
		.btnStart_i(btnStart),
		.btn0_i(btn0),
		.btn1_i(btn1),
		.readEn_i(readEn),
		.lastEntry_o(lastEntry),
		.readOut_o(readOut),
		.readCount1Bcd_o(readCount)
	);

	// push into the model, a full queue drops the packet
	function automatic void modelPush(input int qid, input schedPkg::payload_t payload);
		if (modelCount[qid] < QUEUE_DEPTH) begin
			modelMem[qid][modelCount[qid]] = payload;
			modelCount[qid] = modelCount[qid] + 1;
		end
	endfunction

	// expected read for one tick, pops the model and counts queue 0 reads
	function automatic schedPkg::packet_t predictRead();
		int order [NUM_Q];
		int best;
		int bestScore;
		int score;
		int q;
		schedPkg::packet_t result;
		// tie order 0, 3, 1, 2
		order = '{0, 3, 1, 2};
		best = -1;
		bestScore = 0;
		result = '0;
		for (int k = 0; k < NUM_Q; k++) begin
			q = order[k];
			if (modelCount[q] > 0) begin
				// latency weight 4 - q, reliability weight q + 1
				if (modelCount[q] <= DIRECT_LIMIT) begin
					score = modelCount[q] * (4 - q) + (q + 1);
				end else begin
					score = modelCount[q] * (q + 1) + (4 - q);
				end
				if (best < 0 || score > bestScore) begin
					best = q;
					bestScore = score;
				end
			end
		end
		if (best >= 0) begin
			result.valid = 1'b1;
			result.queueId = schedPkg::qid_t'(best);
			result.payload = modelMem[best][0];
			for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
				modelMem[best][i] = modelMem[best][i + 1];
			end
			modelCount[best] = modelCount[best] - 1;
			if (best == 0) begin
				q0Reads = q0Reads + 1;
			end
		end
		return result;
	endfunction

	// decimal digits of a count, wrapping at 10000
	function automatic schedPkg::bcd_t toBcd(input int n);
		int m;
		m = n % 10000;
		return {4'(m / 1000), 4'((m / 100) % 10), 4'((m / 10) % 10), 4'(m % 10)};
	endfunction

	task automatic checkPacket(input schedPkg::packet_t got, input schedPkg::packet_t exp,
		input string what);
		checkCount = checkCount + 1;
		if (got !== exp) begin
			errorCount = errorCount + 1;
			$display("error at %0t ns: %s is v%0b q%0d p%0d, expected v%0b q%0d p%0d",
				$time, what, got.valid, got.queueId, got.payload,
				exp.valid, exp.queueId, exp.payload);
		end
	endtask

	task automatic checkBcd(input schedPkg::bcd_t got, input schedPkg::bcd_t exp,
		input string what);
		checkCount = checkCount + 1;
		if (got !== exp) begin
			errorCount = errorCount + 1;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount = testCount + 1;
		if (errorCount == errorsBefore) begin
			$display("test %0d %s: passed", testCount, name);
		end else begin
			$display("test %0d %s: FAILED", testCount, name);
		end
	endtask

	// one keyed bit, btn0 for a one and btn1 for a zero, called on a falling edge
	task automatic pressBit(input logic bitVal, input int holdCycles);
		if (bitVal) begin
			btn0 = 1'b0;
		end else begin
			btn1 = 1'b0;
		end
		repeat (holdCycles) @(negedge CLOCK_50);
		btn0 = 1'b1;
		btn1 = 1'b1;
		repeat (RELEASE_CYCLES) @(negedge CLOCK_50);
	endtask

	// start press, then queue id and payload msb first
	task automatic keyPacket(input schedPkg::qid_t qid, input schedPkg::payload_t payload,
		input int holdCycles);
		logic [3:0] bits;
		schedPkg::packet_t expEntry;
		bits = {qid, payload};
		btnStart = 1'b0;
		repeat (2) @(negedge CLOCK_50);
		btnStart = 1'b1;
		repeat (2) @(negedge CLOCK_50);
		for (int i = 3; i >= 0; i--) begin
			pressBit(bits[i], holdCycles);
		end
		modelPush(int'(qid), payload);
		expEntry = {1'b1, qid, payload};
		checkPacket(lastEntry, expEntry, "last entry");
	endtask

	// hold readEn until the checker has seen n ticks
	task automatic runReads(input int n);
		int target;
		target = readsSeen + n;
		readEn = 1'b1;
		wait (readsSeen == target);
		// still on the falling edge of the last tick
		readEn = 1'b0;
	endtask

	// tick timing rebuilt from readEn, result compared a half cycle after the tick
	initial begin
		forever begin
			@(posedge CLOCK_50);
			if (readEn) begin
				readEdges = readEdges + 1;
			end else begin
				readEdges = 0;
			end
			if (readEdges == READ_PERIOD) begin
				readEdges = 0;
				@(negedge CLOCK_50);
				expRead = predictRead();
				checkPacket(readOut, expRead, "read output");
				readsSeen = readsSeen + 1;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		int testErrors;
		logic [31:0] rnd;
		btnStart = 1'b1;
		btn0 = 1'b1;
		btn1 = 1'b1;
		readEn = 1'b0;
		for (int q = 0; q < NUM_Q; q++) begin
			modelCount[q] = 0;
		end
		wait (!rst);
		@(negedge CLOCK_50);

		// reset values
		testErrors = errorCount;
		checkPacket(readOut, '0, "read output after reset");
		checkPacket(lastEntry, '0, "last entry after reset");
		checkBcd(readCount, '0, "read count after reset");
		reportTest("reset values", testErrors);

		// four stray bits before start would make a full packet if taken
		testErrors = errorCount;
		pressBit(1'b1, HOLD_CYCLES);
		pressBit(1'b0, HOLD_CYCLES);
		pressBit(1'b1, HOLD_CYCLES);
		pressBit(1'b1, HOLD_CYCLES);
		checkPacket(lastEntry, '0, "last entry after stray presses");
		// then one long held press per bit
		keyPacket(2'd2, 2'd1, LONG_HOLD);
		reportTest("packet entry", testErrors);

		// random load, then read until everything is drained
		testErrors = errorCount;
		for (int i = 0; i < RANDOM_ENTRIES; i++) begin
			rnd = $random(seed);
			keyPacket(rnd[1:0], rnd[3:2], HOLD_CYCLES);
		end
		runReads(RANDOM_READS);
		reportTest("scheduling order", testErrors);

		// nothing queued
		testErrors = errorCount;
		runReads(1);
		checkPacket(readOut, '0, "read with all queues empty");
		reportTest("empty read", testErrors);

		// one past depth into queue 1, last push is lost
		testErrors = errorCount;
		for (int i = 0; i < FILL_ENTRIES; i++) begin
			rnd = $random(seed);
			keyPacket(2'd1, rnd[1:0], HOLD_CYCLES);
		end
		runReads(FILL_ENTRIES);
		checkPacket(readOut, '0, "read after full queue drained");
		reportTest("full queue drop", testErrors);

		// tally lags the tick by two edges
		testErrors = errorCount;
		repeat (3) @(negedge CLOCK_50);
		checkBcd(readCount, toBcd(q0Reads), "queue 0 read count");
		reportTest("read tally", testErrors);

		$display("tests: %0d, checks: %0d, failed checks: %0d",
			testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: bench/tbClock.sv
`timescale 1ns/100ps

module tbClock #(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 5
) (
	output logic CLOCK_50,
	output logic rst_o
);

	// free running clock, half period each phase
	initial begin
		CLOCK_50 = 1'b0;
		forever begin
			#(PERIOD_NS / 2) CLOCK_50 = ~CLOCK_50;
		end
	end

	// reset held over the first rising edges, released on a falling edge
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst_o = 1'b0;
	end

endmodule

// File: compile.f
verilog/schedPkg.sv
verilog/bitEntry.sv
verilog/packetQueue.sv
verilog/queueArbiter.sv
verilog/readTally.sv
verilog/packetScheduler.sv
bench/tbClock.sv
bench/schedTb.sv

// File: run.sh
#!/bin/sh
# compile and run the packet scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module schedTb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/VschedTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// File: verilog/bitEntry.sv
`timescale 1ns/100ps

module bitEntry (
	input logic CLOCK_50,
	input logic rst_i,
	input logic btnStart_i,
	input logic btn0_i,
	input logic btn1_i,
	output schedPkg::packet_t pushPacket_o,
	output schedPkg::packet_t lastEntry_o
);

	typedef enum logic [1:0] {
		ENTRY_IDLE,
		ENTRY_COLLECT,
		ENTRY_DONE
	} entryState_t;

	entryState_t state;

	// first three keyed bits, oldest in the top bit
	logic [2:0] shiftReg;
	// number of bits already keyed in this packet
	logic [1:0] bitCount;

	// button levels from the previous edge
	logic btn0Prev;
	logic btn1Prev;

	logic bothReleased;
	logic press0;
	logic press1;
	logic keyPress;
	logic keyedBit;

	schedPkg::packet_t newPacket;

	// buttons are active low
	// a press needs both bit buttons up on the previous edge
	assign bothReleased = btn0Prev && btn1Prev;
	assign press0 = bothReleased && !btn0_i && btn1_i;
	assign press1 = bothReleased && btn0_i && !btn1_i;
	// both going low together is not a press
	assign keyPress = press0 || press1;
	// btn0 keys a one, btn1 keys a zero
	assign keyedBit = press0;

	// packet as it looks once the fourth bit arrives
	always_comb begin
		newPacket.valid = 1'b1;
		newPacket.queueId = shiftReg[2:1];
		newPacket.payload = {shiftReg[0], keyedBit};
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst_i) begin
			state <= ENTRY_IDLE;
			shiftReg <= '0;
			bitCount <= '0;
			btn0Prev <= 1'b1;
			btn1Prev <= 1'b1;
			pushPacket_o <= '0;
			lastEntry_o <= '0;
		end else begin
			btn0Prev <= btn0_i;
			btn1Prev <= btn1_i;
			// push strobe lasts a single cycle
			pushPacket_o.valid <= 1'b0;

			case (state)
				ENTRY_IDLE: begin
					// wait for start, bits keyed before it are dropped
					if (!btnStart_i) begin
						shiftReg <= '0;
						bitCount <= '0;
						state <= ENTRY_COLLECT;
					end
				end
				ENTRY_COLLECT: begin
					if (keyPress) begin
						// msb first
						shiftReg <= {shiftReg[1:0], keyedBit};
						bitCount <= bitCount + 2'd1;
						if (bitCount == 2'd3) begin
							pushPacket_o <= newPacket;
							lastEntry_o <= newPacket;
							state <= ENTRY_DONE;
						end
					end
				end
				ENTRY_DONE: begin
					// strobe is out this cycle, back to waiting for start
					state <= ENTRY_IDLE;
				end
				default: begin
					state <= ENTRY_IDLE;
				end
			endcase
		end
	end

endmodule

// File: verilog/packetQueue.sv
`timescale 1ns/100ps

module packetQueue #(
	parameter int QUEUE_DEPTH = 6
) (
	input logic CLOCK_50,
	input logic rst_i,
	input logic push_i,
	input schedPkg::payload_t pushPayload_i,
	input logic pop_i,
	output schedPkg::count_t count_o,
	output schedPkg::payload_t head_o
);

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	// entry storage
	schedPkg::payload_t mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	schedPkg::count_t fillCount;

	logic isFull;
	logic isEmpty;
	logic doPush;
	logic doPop;

	assign isFull = (fillCount == schedPkg::count_t'(QUEUE_DEPTH));
	assign isEmpty = (fillCount == '0);

	// push into a full queue is lost
	assign doPush = push_i && !isFull;
	// pop of an empty queue is a no-op
	assign doPop = pop_i && !isEmpty;

	// oldest entry, only meaningful when count is nonzero
	assign head_o = mem[rdPtr];
	assign count_o = fillCount;

	// storage write
	always_ff @(posedge CLOCK_50) begin
		if (doPush) begin
			mem[wrPtr] <= pushPayload_i;
		end
	end

	// pointers and fill level
	always_ff @(posedge CLOCK_50) begin
		if (rst_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fillCount <= '0;
		end else begin
			if (doPush) begin
				// wrap at the last slot
				if (wrPtr == PTR_W'(QUEUE_DEPTH - 1)) begin
					wrPtr <= '0;
				end else begin
					wrPtr <= wrPtr + 1'b1;
				end
			end
			if (doPop) begin
				if (rdPtr == PTR_W'(QUEUE_DEPTH - 1)) begin
					rdPtr <= '0;
				end else begin
					rdPtr <= rdPtr + 1'b1;
				end
			end
			// push and pop together leave the count alone
			if (doPush && !doPop) begin
				fillCount <= fillCount + 1'b1;
			end else if (doPop && !doPush) begin
				fillCount <= fillCount - 1'b1;
			end
		end
	end

endmodule

// File: verilog/packetScheduler.sv
`timescale 1ns/100ps

module packetScheduler #(
	parameter int QUEUE_DEPTH = 6,
	parameter int READ_PERIOD = 60
) (
	input logic CLOCK_50,
	input logic rst_i,
	input logic btnStart_i,
	input logic btn0_i,
	input logic btn1_i,
	input logic readEn_i,
	output schedPkg::packet_t lastEntry_o,
	output schedPkg::packet_t readOut_o,
	output schedPkg::bcd_t readCount1Bcd_o
);

	// keyed packet, valid for one cycle
	schedPkg::packet_t pushPacket;

	// per queue status into the arbiter
	schedPkg::count_t [schedPkg::NUM_QUEUES-1:0] queueCounts;
	schedPkg::payload_t [schedPkg::NUM_QUEUES-1:0] queueHeads;

	// per queue pop strobes from the arbiter
	logic [schedPkg::NUM_QUEUES-1:0] queuePop;
	// a read came from queue 0
	logic q0Read;

	// button entry
	bitEntry entry (
		.CLOCK_50(CLOCK_50),
		.rst_i(rst_i),
		.btnStart_i(btnStart_i),
		.btn0_i(btn0_i),
		.btn1_i(btn1_i),
		.pushPacket_o(pushPacket),
		.lastEntry_o(lastEntry_o)
	);

	// queue index comes from the loop position
	generate
		for (genvar q = 0; q < schedPkg::NUM_QUEUES; q++) begin : gQueue
			packetQueue #(
				.QUEUE_DEPTH(QUEUE_DEPTH)
			) queue (
				.CLOCK_50(CLOCK_50),
				.rst_i(rst_i),
				.push_i(pushPacket.valid && (pushPacket.queueId == schedPkg::qid_t'(q))),
				.pushPayload_i(pushPacket.payload),
				.pop_i(queuePop[q]),
				.count_o(queueCounts[q]),
				.head_o(queueHeads[q])
			);
		end
	endgenerate

	// read tick and queue choice
	queueArbiter #(
		.READ_PERIOD(READ_PERIOD)
	) arbiter (
		.CLOCK_50(CLOCK_50),
		.rst_i(rst_i),
		.readEn_i(readEn_i),
		.counts_i(queueCounts),
		.heads_i(queueHeads),
		.pop_o(queuePop),
		.q0Read_o(q0Read),
		.readOut_o(readOut_o)
	);

	// decimal count of queue 0 reads
	readTally tally (
		.CLOCK_50(CLOCK_50),
		.rst_i(rst_i),
		.inc_i(q0Read),
		.value_o(readCount1Bcd_o)
	);

endmodule

// File: verilog/queueArbiter.sv
`timescale 1ns/100ps

module queueArbiter #(
	parameter int READ_PERIOD = 60
) (
	input logic CLOCK_50,
	input logic rst_i,
	input logic readEn_i,
	input schedPkg::count_t [schedPkg::NUM_QUEUES-1:0] counts_i,
	input schedPkg::payload_t [schedPkg::NUM_QUEUES-1:0] heads_i,
	output logic [schedPkg::NUM_QUEUES-1:0] pop_o,
	output logic q0Read_o,
	output schedPkg::packet_t readOut_o
);

	localparam int CNT_W = $clog2(READ_PERIOD + 1);

	// tie break order 0, 3, 1, 2, first slot is checked first
	localparam schedPkg::qid_t [schedPkg::NUM_QUEUES-1:0] TIE_ORDER = {
		2'd2,
		2'd1,
		2'd3,
		2'd0
	};

	logic [CNT_W-1:0] tickCount;
	logic tick;

	schedPkg::score_t scores [schedPkg::NUM_QUEUES];

	logic bestFound;
	schedPkg::qid_t bestId;
	schedPkg::score_t bestScore;
	schedPkg::qid_t candId;

	// score of one queue from its fill level and weights
	function automatic schedPkg::score_t queueScore(
		input schedPkg::count_t fill,
		input logic [2:0] latency,
		input logic [2:0] reliability
	);
		if (fill == '0) begin
			// empty queue, never chosen
			return '0;
		end else if (fill <= schedPkg::count_t'(schedPkg::DIRECT_LIMIT)) begin
			// short queue favours low latency
			return schedPkg::score_t'(fill) * schedPkg::score_t'(latency)
				+ schedPkg::score_t'(reliability);
		end else begin
			// long queue favours reliability
			return schedPkg::score_t'(fill) * schedPkg::score_t'(reliability)
				+ schedPkg::score_t'(latency);
		end
	endfunction

	// tick on the READ_PERIOD-th edge with readEn high
	assign tick = readEn_i && (tickCount == CNT_W'(READ_PERIOD - 1));

	always_ff @(posedge CLOCK_50) begin
		if (rst_i || !readEn_i) begin
			tickCount <= '0;
		end else if (tick) begin
			tickCount <= '0;
		end else begin
			tickCount <= tickCount + 1'b1;
		end
	end

	// scores from the current fill levels
	always_comb begin
		for (int q = 0; q < schedPkg::NUM_QUEUES; q++) begin
			scores[q] = queueScore(counts_i[q], schedPkg::LATENCY_W[q],
				schedPkg::RELIABILITY_W[q]);
		end
	end

	// highest score wins, strict compare keeps the earlier queue on a tie
	always_comb begin
		bestFound = 1'b0;
		bestId = '0;
		bestScore = '0;
		candId = '0;
		for (int k = 0; k < schedPkg::NUM_QUEUES; k++) begin
			candId = TIE_ORDER[k];
			if (counts_i[candId] != '0) begin
				if (!bestFound || scores[candId] > bestScore) begin
					bestFound = 1'b1;
					bestId = candId;
					bestScore = scores[candId];
				end
			end
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst_i) begin
			pop_o <= '0;
			q0Read_o <= 1'b0;
			readOut_o <= '0;
		end else begin
			// strobes are one cycle wide
			pop_o <= '0;
			q0Read_o <= 1'b0;
			if (tick) begin
				if (bestFound) begin
					readOut_o.valid <= 1'b1;
					readOut_o.queueId <= bestId;
					readOut_o.payload <= heads_i[bestId];
					// queue pops on the next edge
					pop_o[bestId] <= 1'b1;
					q0Read_o <= (bestId == 2'd0);
				end else begin
					// nothing queued, show an empty read
					readOut_o <= '0;
				end
			end
		end
	end

endmodule

// File: verilog/readTally.sv
`timescale 1ns/100ps

module readTally (
	input logic CLOCK_50,
	input logic rst_i,
	input logic inc_i,
	output schedPkg::bcd_t value_o
);

	localparam int DIGITS = 4;

	schedPkg::bcd_t tally;

	// increment request reaching each digit, units digit first
	logic [DIGITS-1:0] carryIn;
	logic ripple;

	// carry moves up past every digit sitting at nine
	always_comb begin
		ripple = inc_i;
		for (int d = 0; d < DIGITS; d++) begin
			carryIn[d] = ripple;
			ripple = ripple && (tally[d*4 +: 4] == 4'd9);
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst_i) begin
			tally <= '0;
		end else begin
			for (int d = 0; d < DIGITS; d++) begin
				if (carryIn[d]) begin
					// nine rolls to zero, 9999 wraps to 0000
					if (tally[d*4 +: 4] == 4'd9) begin
						tally[d*4 +: 4] <= 4'd0;
					end else begin
						tally[d*4 +: 4] <= tally[d*4 +: 4] + 4'd1;
					end
				end
			end
		end
	end

	assign value_o = tally;

endmodule

// File: verilog/schedPkg.sv
package schedPkg;

	// four queues, one per value of the two-bit queue id
	localparam int NUM_QUEUES = 4;

	// queue index taken from the first two keyed bits
	typedef logic [1:0] qid_t;

	// payload taken from the last two keyed bits
	typedef logic [1:0] payload_t;

	// fill level of one queue, wide enough for a depth of six
	typedef logic [2:0] count_t;

	// scheduling score, max is 6 * 4 + 1
	typedef logic [4:0] score_t;

	// four bcd digits, thousands digit in the top nibble
	typedef logic [15:0] bcd_t;

	// one keyed packet as pushed, shown and read out
	typedef struct packed {
		logic valid;
		qid_t queueId;
		payload_t payload;
	} packet_t;

	// latency weight per queue, queue 0 in the low slot
	localparam logic [NUM_QUEUES-1:0][2:0] LATENCY_W = {
		3'd1,
		3'd2,
		3'd3,
		3'd4
	};

	// reliability weight per queue, queue 0 in the low slot
	localparam logic [NUM_QUEUES-1:0][2:0] RELIABILITY_W = {
		3'd4,
		3'd3,
		3'd2,
		3'd1
	};

	// fill levels up to here use the latency-weighted score
	localparam int DIRECT_LIMIT = 3;

endpackage
